// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dec_exe_core
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== core_pkg.sv ====
// Core decode and execute definitions

package core_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// Bubble encoding is the canonical add x0,x0,x0
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0033;

	// Bit positions follow the RISC-V cause numbers
	localparam int EXC_MISALIGN = 0;
	localparam int EXC_ILLEGAL  = 2;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_JUMP
	} br_op_e;

	typedef struct packed {
		logic [6:0]        funct7;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} r_fmt_s;

	typedef struct packed {
		logic [11:0]       imm;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} i_fmt_s;

	typedef struct packed {
		logic              imm12;
		logic [5:0]        imm10_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [3:0]        imm4_1;
		logic              imm11;
		logic [6:0]        opcode;
	} b_fmt_s;

	typedef struct packed {
		logic              imm20;
		logic [9:0]        imm10_1;
		logic              imm11;
		logic [7:0]        imm19_12;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} j_fmt_s;

	typedef union packed {
		r_fmt_s r;
		i_fmt_s i;
		b_fmt_s b;
		j_fmt_s j;
	} instr_u;

	typedef struct packed {
		instr_u          instr;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] pred_pc;
		logic            pred;
		logic            valid;
	} fetch_s;

	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   op_a;
		logic [XLEN-1:0]   op_b;
		logic [XLEN-1:0]   imm;
		alu_op_e           alu_op;
		br_op_e            br_op;
		logic              b_is_imm;
		logic [REG_AW-1:0] rd;
		logic              we;
		logic [XLEN-1:0]   exc;
		instr_u            instr;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   pred_pc;
		logic              pred;
	} dec_exe_s;

	typedef struct packed {
		logic              valid;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   data;
	} wb_s;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
	} redirect_s;

endpackage

// ==== dec_exe_core.sv ====
// Decode and execute slice top
`timescale 1ns/100ps

module dec_exe_core (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      stall_i,
	input  core_pkg::fetch_s          fetch_i,
	output core_pkg::wb_s             wb_o,
	output core_pkg::redirect_s       redirect_o,
	output logic [core_pkg::XLEN-1:0] exc_o
);

	logic [core_pkg::REG_AW-1:0] raddr_a;
	logic [core_pkg::REG_AW-1:0] raddr_b;
	logic [core_pkg::XLEN-1:0]   rdata_a;
	logic [core_pkg::XLEN-1:0]   rdata_b;
	logic                        rf_we;
	logic [core_pkg::REG_AW-1:0] rf_waddr;
	logic [core_pkg::XLEN-1:0]   rf_wdata;
	logic                        kill;
	core_pkg::dec_exe_s          dec_bundle;
	core_pkg::dec_exe_s          exe_bundle;

	reg_file u_reg_file (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.raddr_a_i (raddr_a),
		.raddr_b_i (raddr_b),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b),
		.we_i      (rf_we),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata)
	);

	decode_stage u_decode_stage (
		.fetch_i   (fetch_i),
		.raddr_a_o (raddr_a),
		.raddr_b_o (raddr_b),
		.rdata_a_i (rdata_a),
		.rdata_b_i (rdata_b),
		.dec_o     (dec_bundle)
	);

	dec_exe_reg u_dec_exe_reg (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.kill_i  (kill),
		.stall_i (stall_i),
		.dec_i   (dec_bundle),
		.exe_o   (exe_bundle)
	);

	exe_stage u_exe_stage (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.exe_i      (exe_bundle),
		.kill_o     (kill),
		.rf_we_o    (rf_we),
		.rf_waddr_o (rf_waddr),
		.rf_wdata_o (rf_wdata),
		.wb_o       (wb_o),
		.redirect_o (redirect_o),
		.exc_o      (exc_o)
	);

endmodule

// ==== dec_exe_core_props.sv ====
// Decode and execute pipeline properties
`timescale 1ns/100ps

module dec_exe_core_props (
	input logic                clk_i,
	input logic                rst_n_i,
	input logic                stall_i,
	input logic                kill_i,
	input core_pkg::wb_s       wb_i,
	input core_pkg::redirect_s redirect_i
);

	int stall_fails    = 0;
	int kill_fails     = 0;
	int rd_fails       = 0;
	int redirect_fails = 0;

	// Execute only sees a bubble while stalled, so nothing retires from that cycle
	stall_no_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> !wb_i.valid)
	else begin
		$error("A writeback appeared after a stall cycle");
		stall_fails++;
	end

	// The flushed slot reaches the writeback register two edges after the kill
	kill_no_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		kill_i |-> ##2 !wb_i.valid)
	else begin
		$error("A killed instruction produced a writeback");
		kill_fails++;
	end

	wb_not_x0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.valid |-> wb_i.rd != '0)
	else begin
		$error("Writeback targeted x0");
		rd_fails++;
	end

	redirect_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		kill_i |=> redirect_i.valid ##1 !redirect_i.valid)
	else begin
		$error("Redirect did not pulse for exactly one cycle after a kill");
		redirect_fails++;
	end

endmodule

bind dec_exe_core dec_exe_core_props u_dec_exe_core_props (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.stall_i    (stall_i),
	.kill_i     (kill),
	.wb_i       (wb_o),
	.redirect_i (redirect_o)
);

// ==== dec_exe_patterns.txt ====
// stall valid instr pc pred_pc pred wb_valid wb_rd wb_data redir_valid redir_pc exc
// Expected columns hold the outputs after the rising edge that follows the line's stimulus
0 0 00000000 00000000 00000000 0 0 00 00000000 0 00000000 00000000
// ALU register and immediate forms with back-to-back dependencies
0 1 00500093 00000100 00000104 0 0 00 00000000 0 00000000 00000000
0 1 FFD00113 00000104 00000108 0 1 01 00000005 0 00000000 00000000
0 1 002081B3 00000108 0000010C 0 1 02 FFFFFFFD 0 00000000 00000000
0 1 40208233 0000010C 00000110 0 1 03 00000002 0 00000000 00000000
0 1 0041F2B3 00000110 00000114 0 1 04 00000008 0 00000000 00000000
0 1 0041E333 00000114 00000118 0 1 05 00000000 0 00000000 00000000
0 1 002343B3 00000118 0000011C 0 1 06 0000000A 0 00000000 00000000
0 1 00112433 0000011C 00000120 0 1 07 FFFFFFF7 0 00000000 00000000
0 1 FFF0A493 00000120 00000124 0 1 08 00000001 0 00000000 00000000
0 1 0F03F513 00000124 00000128 0 1 09 00000000 0 00000000 00000000
0 1 00F56593 00000128 0000012C 0 1 0A 000000F0 0 00000000 00000000
0 1 FFF5C613 0000012C 00000130 0 1 0B 000000FF 0 00000000 00000000
0 1 123456B7 00000130 00000134 0 1 0C FFFFFF00 0 00000000 00000000
0 1 00708013 00000134 00000138 0 1 0D 12345000 0 00000000 00000000
0 1 00D00733 00000138 0000013C 0 0 00 00000000 0 00000000 00000000
// Stall holds addi x15 while the fetch side offers an instruction that must be ignored
0 1 05500793 0000013C 00000140 0 1 0E 12345000 0 00000000 00000000
1 1 7FF00893 00000140 00000144 0 0 00 00000000 0 00000000 00000000
1 1 7FF00893 00000140 00000144 0 0 00 00000000 0 00000000 00000000
0 1 00178813 00000140 00000144 0 1 0F 00000055 0 00000000 00000000
0 1 01088933 00000144 00000148 0 1 10 00000056 0 00000000 00000000
// Correctly predicted beq, bne and jal
0 1 00108463 00000148 00000150 1 1 12 00000056 0 00000000 00000000
0 1 00319863 00000150 00000154 0 0 00 00000000 0 00000000 00000000
0 1 020009EF 00000154 00000174 1 0 00 00000000 0 00000000 00000000
// Mispredicted blt and beq, each followed by a wrong-path instruction
0 1 00114663 00000174 00000178 0 1 13 00000158 0 00000000 00000000
0 1 09900A13 00000178 0000017C 0 0 00 00000000 1 00000180 00000000
0 1 001A0AB3 00000180 00000184 0 0 00 00000000 0 00000000 00000000
0 1 00208463 00000184 0000018C 1 1 15 00000005 0 00000000 00000000
0 1 00100B13 0000018C 00000190 0 0 00 00000000 1 00000188 00000000
0 1 001B0B33 00000188 0000018C 0 0 00 00000000 0 00000000 00000000
// Illegal opcode, unsupported sll, misaligned beq and jal targets
0 1 0000007F 0000018C 00000190 0 1 16 00000005 0 00000000 00000000
0 1 001090B3 00000190 00000194 0 0 00 00000000 0 00000000 00000004
0 1 00000363 00000194 00000198 0 0 00 00000000 0 00000000 00000004
0 1 00200BEF 00000198 0000019C 0 0 00 00000000 0 00000000 00000001
0 1 00008C33 0000019C 000001A0 0 0 00 00000000 0 00000000 00000001
0 0 00000000 00000000 00000000 0 1 18 00000005 0 00000000 00000000
0 0 00000000 00000000 00000000 0 0 00 00000000 0 00000000 00000000

// ==== dec_exe_reg.sv ====
// Decode to execute pipeline register
`timescale 1ns/100ps

module dec_exe_reg (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               kill_i,
	input  logic               stall_i,
	input  core_pkg::dec_exe_s dec_i,
	output core_pkg::dec_exe_s exe_o
);

	core_pkg::dec_exe_s held_q;

	// Kill takes priority, so a flush during a stall still empties the slot
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			held_q <= '0;
		end else if (kill_i) begin
			held_q <= '0;
		end else if (!stall_i) begin
			held_q <= dec_i;
		end
	end

	// Execute sees a bubble while the held bundle waits
	always_comb begin
		exe_o = held_q;
		if (stall_i) begin
			exe_o       = '0;
			exe_o.instr = core_pkg::NOP_INSTR;
		end
	end

endmodule

// ==== decode_stage.sv ====
// Instruction decode stage
`timescale 1ns/100ps

module decode_stage (
	input  core_pkg::fetch_s            fetch_i,
	output logic [core_pkg::REG_AW-1:0] raddr_a_o,
	output logic [core_pkg::REG_AW-1:0] raddr_b_o,
	input  logic [core_pkg::XLEN-1:0]   rdata_a_i,
	input  logic [core_pkg::XLEN-1:0]   rdata_b_i,
	output core_pkg::dec_exe_s          dec_o
);

	core_pkg::instr_u          instr;
	core_pkg::alu_op_e         alu_op;
	core_pkg::br_op_e          br_op;
	logic [core_pkg::XLEN-1:0] imm;
	logic [core_pkg::XLEN-1:0] imm_i;
	logic [core_pkg::XLEN-1:0] imm_b;
	logic [core_pkg::XLEN-1:0] imm_j;
	logic [core_pkg::XLEN-1:0] imm_u;
	logic                      b_is_imm;
	logic                      use_rs1;
	logic                      use_rs2;
	logic                      writes_rd;
	logic                      legal;

	assign instr = fetch_i.instr;

	assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign imm_b = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	assign imm_j = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};
	// U immediate occupies the same upper bits the J view splits up
	assign imm_u = {instr.j.imm20, instr.j.imm10_1, instr.j.imm11, instr.j.imm19_12, 12'b0};

	always_comb begin
		alu_op    = core_pkg::ALU_ADD;
		br_op     = core_pkg::BR_NONE;
		imm       = '0;
		b_is_imm  = 1'b0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		writes_rd = 1'b0;
		legal     = 1'b1;
		case (instr.r.opcode)
			core_pkg::OPC_OP: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				writes_rd = 1'b1;
				case ({instr.r.funct7, instr.r.funct3})
					{7'h00, 3'b000}: alu_op = core_pkg::ALU_ADD;
					{7'h20, 3'b000}: alu_op = core_pkg::ALU_SUB;
					{7'h00, 3'b010}: alu_op = core_pkg::ALU_SLT;
					{7'h00, 3'b100}: alu_op = core_pkg::ALU_XOR;
					{7'h00, 3'b110}: alu_op = core_pkg::ALU_OR;
					{7'h00, 3'b111}: alu_op = core_pkg::ALU_AND;
					default:         legal  = 1'b0;
				endcase
			end
			core_pkg::OPC_OP_IMM: begin
				use_rs1   = 1'b1;
				writes_rd = 1'b1;
				b_is_imm  = 1'b1;
				imm       = imm_i;
				case (instr.i.funct3)
					3'b000:  alu_op = core_pkg::ALU_ADD;
					3'b010:  alu_op = core_pkg::ALU_SLT;
					3'b100:  alu_op = core_pkg::ALU_XOR;
					3'b110:  alu_op = core_pkg::ALU_OR;
					3'b111:  alu_op = core_pkg::ALU_AND;
					default: legal  = 1'b0;
				endcase
			end
			core_pkg::OPC_LUI: begin
				writes_rd = 1'b1;
				b_is_imm  = 1'b1;
				imm       = imm_u;
				alu_op    = core_pkg::ALU_PASS_B;
			end
			core_pkg::OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm     = imm_b;
				case (instr.b.funct3)
					3'b000:  br_op = core_pkg::BR_EQ;
					3'b001:  br_op = core_pkg::BR_NE;
					3'b100:  br_op = core_pkg::BR_LT;
					default: legal = 1'b0;
				endcase
			end
			core_pkg::OPC_JAL: begin
				writes_rd = 1'b1;
				imm       = imm_j;
				br_op     = core_pkg::BR_JUMP;
			end
			default: legal = 1'b0;
		endcase
	end

	assign raddr_a_o = (fetch_i.valid && use_rs1) ? instr.r.rs1 : '0;
	assign raddr_b_o = (fetch_i.valid && use_rs2) ? instr.r.rs2 : '0;

	always_comb begin
		dec_o       = '0;
		dec_o.instr = core_pkg::NOP_INSTR;
		if (fetch_i.valid) begin
			dec_o.valid    = 1'b1;
			dec_o.op_a     = rdata_a_i;
			dec_o.op_b     = rdata_b_i;
			dec_o.imm      = imm;
			dec_o.alu_op   = alu_op;
			dec_o.br_op    = legal ? br_op : core_pkg::BR_NONE;
			dec_o.b_is_imm = b_is_imm;
			dec_o.rd       = (legal && writes_rd) ? instr.r.rd : '0;
			dec_o.we       = legal && writes_rd && (instr.r.rd != '0);
			dec_o.exc[core_pkg::EXC_ILLEGAL] = !legal;
			dec_o.instr    = instr;
			dec_o.pc       = fetch_i.pc;
			dec_o.pred_pc  = fetch_i.pred_pc;
			dec_o.pred     = fetch_i.pred;
		end
	end

endmodule

// ==== exe_stage.sv ====
// Execute stage with branch resolution
`timescale 1ns/100ps

module exe_stage (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  core_pkg::dec_exe_s          exe_i,
	output logic                        kill_o,
	output logic                        rf_we_o,
	output logic [core_pkg::REG_AW-1:0] rf_waddr_o,
	output logic [core_pkg::XLEN-1:0]   rf_wdata_o,
	output core_pkg::wb_s               wb_o,
	output core_pkg::redirect_s         redirect_o,
	output logic [core_pkg::XLEN-1:0]   exc_o
);

	logic [core_pkg::XLEN-1:0] op_b;
	logic [core_pkg::XLEN-1:0] alu_res;
	logic [core_pkg::XLEN-1:0] pc_plus4;
	logic [core_pkg::XLEN-1:0] target;
	logic [core_pkg::XLEN-1:0] next_pc;
	logic [core_pkg::XLEN-1:0] exc;
	logic                      taken;
	logic                      misalign;
	logic                      resolve;

	assign op_b = exe_i.b_is_imm ? exe_i.imm : exe_i.op_b;

	always_comb begin
		case (exe_i.alu_op)
			core_pkg::ALU_ADD:    alu_res = exe_i.op_a + op_b;
			core_pkg::ALU_SUB:    alu_res = exe_i.op_a - op_b;
			core_pkg::ALU_AND:    alu_res = exe_i.op_a & op_b;
			core_pkg::ALU_OR:     alu_res = exe_i.op_a | op_b;
			core_pkg::ALU_XOR:    alu_res = exe_i.op_a ^ op_b;
			core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(exe_i.op_a) < $signed(op_b)};
			core_pkg::ALU_PASS_B: alu_res = op_b;
			default:              alu_res = '0;
		endcase
	end

	// Branches always compare the two register operands
	always_comb begin
		case (exe_i.br_op)
			core_pkg::BR_EQ:   taken = exe_i.op_a == exe_i.op_b;
			core_pkg::BR_NE:   taken = exe_i.op_a != exe_i.op_b;
			core_pkg::BR_LT:   taken = $signed(exe_i.op_a) < $signed(exe_i.op_b);
			core_pkg::BR_JUMP: taken = 1'b1;
			default:           taken = 1'b0;
		endcase
	end

	assign pc_plus4 = exe_i.pc + 32'd4;
	assign target   = exe_i.pc + exe_i.imm;
	assign next_pc  = taken ? target : pc_plus4;
	assign misalign = taken && (target[1:0] != 2'b00);

	// Bubbles and decode exceptions never redirect fetch
	assign resolve = exe_i.valid && (exe_i.exc == '0);

	always_comb begin
		exc = exe_i.exc;
		exc[core_pkg::EXC_MISALIGN] = exe_i.valid && misalign;
	end

	assign kill_o     = resolve && !misalign && (next_pc != exe_i.pred_pc);
	assign rf_we_o    = exe_i.we && !misalign;
	assign rf_waddr_o = exe_i.rd;
	assign rf_wdata_o = (exe_i.br_op == core_pkg::BR_JUMP) ? pc_plus4 : alu_res;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_o       <= '0;
			redirect_o <= '0;
			exc_o      <= '0;
		end else begin
			wb_o       <= rf_we_o ? '{valid: 1'b1, rd: rf_waddr_o, data: rf_wdata_o} : '0;
			redirect_o <= kill_o ? '{valid: 1'b1, pc: next_pc} : '0;
			exc_o      <= exc;
		end
	end

endmodule

// ==== reg_file.sv ====
// Integer register file
`timescale 1ns/100ps

module reg_file (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
	input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
	output logic [core_pkg::XLEN-1:0]   rdata_a_o,
	output logic [core_pkg::XLEN-1:0]   rdata_b_o,
	input  logic                       we_i,
	input  logic [core_pkg::REG_AW-1:0] waddr_i,
	input  logic [core_pkg::XLEN-1:0]   wdata_i
);

	localparam int NUM_REGS = 2 ** core_pkg::REG_AW;

	logic [core_pkg::XLEN-1:0] regs [NUM_REGS];
	logic                      wr_live;

	// x0 is never written, so it keeps its reset value of zero
	assign wr_live = we_i && (waddr_i != '0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Write-through lets decode see the value execute is retiring this cycle
	assign rdata_a_o = (wr_live && (raddr_a_i == waddr_i)) ? wdata_i : regs[raddr_a_i];
	assign rdata_b_o = (wr_live && (raddr_b_i == waddr_i)) ? wdata_i : regs[raddr_b_i];

endmodule

// ==== tb_dec_exe_core.sv ====
// Decode and execute slice testbench
`timescale 1ns/100ps

module tb_dec_exe_core;

	localparam int FIELDS    = 12;
	localparam int MAX_LINES = 64;
	localparam int MEM_WORDS = FIELDS * MAX_LINES;

	logic                      clk_i;
	logic                      rst_n_i;
	logic                      stall_i;
	core_pkg::fetch_s          fetch_i;
	core_pkg::wb_s             wb_o;
	core_pkg::redirect_s       redirect_o;
	logic [core_pkg::XLEN-1:0] exc_o;

	logic [31:0] pat_mem [MEM_WORDS];
	int          num_lines   = 0;
	int          cycle_limit = 0;
	int          cycles      = 0;
	int          errors      = 0;
	int          timeouts    = 0;

	dec_exe_core u_dec_exe_core (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.stall_i    (stall_i),
		.fetch_i    (fetch_i),
		.wb_o       (wb_o),
		.redirect_o (redirect_o),
		.exc_o      (exc_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	// A real row starts with a stall flag of 0 or 1 and the fill marker never does
	function automatic int count_lines();
		int n;
		n = 0;
		while (n < MAX_LINES && pat_mem[n * FIELDS] <= 32'd1) begin
			n++;
		end
		return n;
	endfunction

	task automatic drive_line(input int line);
		int base;
		base = line * FIELDS;
		stall_i         = pat_mem[base][0];
		fetch_i.valid   = pat_mem[base + 1][0];
		fetch_i.instr   = pat_mem[base + 2];
		fetch_i.pc      = pat_mem[base + 3];
		fetch_i.pred_pc = pat_mem[base + 4];
		fetch_i.pred    = pat_mem[base + 5][0];
	endtask

	task automatic compare_line(input int line);
		int base;
		base = line * FIELDS;
		check($sformatf("wb_o.valid (line %0d)", line), pat_mem[base + 6], {31'b0, wb_o.valid});
		check($sformatf("wb_o.rd (line %0d)", line), pat_mem[base + 7], {27'b0, wb_o.rd});
		check($sformatf("wb_o.data (line %0d)", line), pat_mem[base + 8], wb_o.data);
		check($sformatf("redirect_o.valid (line %0d)", line), pat_mem[base + 9],
			{31'b0, redirect_o.valid});
		check($sformatf("redirect_o.pc (line %0d)", line), pat_mem[base + 10], redirect_o.pc);
		check($sformatf("exc_o (line %0d)", line), pat_mem[base + 11], exc_o);
	endtask

	// Outputs are registered, so a quarter period after the edge they are settled
	task automatic run_patterns();
		for (int k = 0; k < num_lines; k++) begin
			@(negedge clk_i);
			drive_line(k);
			@(posedge clk_i);
			#25;
			compare_line(k);
		end
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = u_dec_exe_core.u_dec_exe_core_props.stall_fails
			+ u_dec_exe_core.u_dec_exe_core_props.kill_fails
			+ u_dec_exe_core.u_dec_exe_core_props.rd_fails
			+ u_dec_exe_core.u_dec_exe_core_props.redirect_fails;
		$display("Errors: %0d, assertion failures: %0d, timeouts: %0d",
			errors, assert_fails, timeouts);
		if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin
		rst_n_i = 1'b0;
		stall_i = 1'b0;
		fetch_i = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			pat_mem[i] = 32'hbad0_0000 | i;
		end
		$readmemh("dec_exe_patterns.txt", pat_mem);
		num_lines   = count_lines();
		cycle_limit = num_lines + 20;
		repeat (5) @(negedge clk_i);
		rst_n_i = 1'b1;
		if (num_lines == 0) begin
			$display("No stimulus lines were found in dec_exe_patterns.txt");
			errors++;
		end else begin
			run_patterns();
		end
		finish_run();
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		timeouts++;
		finish_run();
	end

endmodule

// ==== vlog.f ====
core_pkg.sv
reg_file.sv
decode_stage.sv
dec_exe_reg.sv
exe_stage.sv
dec_exe_core.sv
dec_exe_core_props.sv
tb_dec_exe_core.sv
